/* logic/dma_bus_pkg.sv */
// System bus types shared by the DMA engine and bus slaves
package dma_bus_pkg;

	// Data word carried on the bus
	typedef logic [31:0] word_t;

	// Byte address, word aligned for every transfer
	typedef logic [31:0] addr_t;

	// Address increment between consecutive words
	localparam addr_t ADDR_STEP = 32'd4;

	// One bus access, held stable by the master until ready
	typedef struct packed {
		logic  rw;      // 1 = write, 0 = read
		addr_t address;
		word_t wdata;   // Only meaningful on writes
	} bus_req_t;

endpackage

/* logic/dma_cmd_pkg.sv */
// DMA command types, CPU register indices and the queued command record
package dma_cmd_pkg;

	// Transfer kind, written through the control register
	typedef enum logic [1:0] {
		NONE  = 2'd0,  // Retires with no bus traffic
		WRITE = 2'd1,  // Fill with a constant
		COPY  = 2'd2,  // Stepping source to stepping destination
		FEED  = 2'd3   // Stepping source to a fixed destination
	} dma_type_t;

	// Sequence number handed to each enqueued command
	typedef logic [31:0] tag_t;

	// Word index inside the CPU register window
	typedef logic [1:0] reg_index_t;

	localparam reg_index_t REG_VALUE_FROM = 2'd0;  // Reads back the queued counter
	localparam reg_index_t REG_TO         = 2'd1;  // Reads back the retired counter
	localparam reg_index_t REG_COUNT      = 2'd2;
	localparam reg_index_t REG_CONTROL    = 2'd3;  // Write enqueues, read gives status

	// Command as stored in the queue
	typedef struct packed {
		dma_type_t             dt;
		dma_bus_pkg::word_t    value_or_from;  // Fill value for WRITE, source otherwise
		dma_bus_pkg::addr_t    to;
		dma_bus_pkg::word_t    count;          // Words to move, minus one
		tag_t                  tag;
	} dma_command_t;

endpackage

/* logic/dma_cmd_fifo.sv */
// Command queue, a show-ahead circular FIFO with full and empty flags
`timescale 1ns/1ps

module dma_cmd_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                      i_clock,
	input  logic                      i_rst_n,
	input  logic                      i_write,
	input  dma_cmd_pkg::dma_command_t i_wdata,
	input  logic                      i_read,
	output dma_cmd_pkg::dma_command_t o_rdata,
	output logic                      o_empty,
	output logic                      o_full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dma_cmd_pkg::dma_command_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] occupancy;
	logic             do_write;
	logic             do_read;

	assign do_write = i_write && !o_full;  // Writes to a full queue are dropped
	assign do_read  = i_read && !o_empty;

	assign o_empty = (occupancy == '0);
	assign o_full  = (occupancy == CNT_W'(DEPTH));
	assign o_rdata = mem[rd_ptr];  // Head entry, valid while not empty

	always_ff @(posedge i_clock) begin
		if (do_write)
			mem[wr_ptr] <= i_wdata;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous read and write leaves the count alone
			if (do_write && !do_read)
				occupancy <= occupancy + 1'b1;
			else if (do_read && !do_write)
				occupancy <= occupancy - 1'b1;
		end
	end

endmodule

/* logic/dma_regs.sv */
// CPU register window that assembles commands, enqueues them and reports counters
`timescale 1ns/1ps

module dma_regs (
	input  logic                      i_clock,
	input  logic                      i_rst_n,

	// CPU side
	input  logic                      i_request,
	input  logic                      i_rw,
	input  dma_cmd_pkg::reg_index_t   i_address,
	input  dma_bus_pkg::word_t        i_wdata,
	output dma_bus_pkg::word_t        o_rdata,
	output logic                      o_ready,

	// Command queue
	output logic                      o_q_write,
	output dma_cmd_pkg::dma_command_t o_q_command,
	input  logic                      i_q_full,
	input  logic                      i_q_empty,

	// Engine
	input  logic                      i_engine_busy,
	input  logic                      i_retire,
	input  dma_cmd_pkg::tag_t         i_retire_tag
);
	dma_bus_pkg::word_t value_or_from;
	dma_bus_pkg::addr_t to;
	dma_bus_pkg::word_t count;

	dma_cmd_pkg::tag_t  queued_count;
	dma_cmd_pkg::tag_t  retired_count;
	dma_cmd_pkg::tag_t  next_tag;

	logic               accept;   // New access seen this cycle
	logic               is_ctrl_write;
	logic               enqueue;
	logic               ack;
	logic               busy;
	dma_bus_pkg::word_t read_word;

	assign accept        = i_request && !o_ready;
	assign is_ctrl_write = i_rw && (i_address == dma_cmd_pkg::REG_CONTROL);
	assign enqueue       = accept && is_ctrl_write && !i_q_full;
	// Control write waits here until the queue has room
	assign ack           = accept && !(is_ctrl_write && i_q_full);

	assign next_tag = queued_count + 1'b1;
	assign busy     = !i_q_empty || i_engine_busy;

	// Command goes straight into the queue on the accepting edge
	assign o_q_write   = enqueue;
	assign o_q_command = '{
		dt:            dma_cmd_pkg::dma_type_t'(i_wdata[1:0]),
		value_or_from: value_or_from,
		to:            to,
		count:         count,
		tag:           next_tag
	};

	always_comb begin
		unique case (i_address)
			dma_cmd_pkg::REG_VALUE_FROM: read_word = queued_count;
			dma_cmd_pkg::REG_TO:         read_word = retired_count;
			dma_cmd_pkg::REG_COUNT:      read_word = '0;
			default:                     read_word = {30'd0, i_q_full, busy};
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready       <= 1'b0;
			queued_count  <= '0;
			retired_count <= '0;
		end else begin
			if (ack)
				o_ready <= 1'b1;
			else if (!i_request)
				o_ready <= 1'b0;  // Handshake closes once the CPU lets go

			if (enqueue)
				queued_count <= next_tag;
			if (i_retire)
				retired_count <= i_retire_tag;
		end
	end

	// Command fields and read data
	always_ff @(posedge i_clock) begin
		if (accept && i_rw) begin
			case (i_address)
				dma_cmd_pkg::REG_VALUE_FROM: value_or_from <= i_wdata;
				dma_cmd_pkg::REG_TO:         to <= i_wdata;
				dma_cmd_pkg::REG_COUNT:      count <= i_wdata;
				default: ;
			endcase
		end
		if (accept && !i_rw)
			o_rdata <= read_word;
	end

endmodule

/* logic/dma_engine.sv */
// DMA engine FSM that takes queued commands and runs them as bus master
`timescale 1ns/1ps

module dma_engine (
	input  logic                      i_clock,
	input  logic                      i_rst_n,

	// Command queue
	input  logic                      i_q_empty,
	input  dma_cmd_pkg::dma_command_t i_q_command,
	output logic                      o_q_read,

	// Status and retirement
	output logic                      o_busy,
	output logic                      o_retire,
	output dma_cmd_pkg::tag_t         o_retire_tag,

	// System bus master
	output logic                      o_bus_request,
	output dma_bus_pkg::bus_req_t     o_bus_req,
	input  logic                      i_bus_ready,
	input  dma_bus_pkg::word_t        i_bus_rdata
);
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		RD_REQ     = 3'd1,
		RD_WAIT    = 3'd2,
		WR_REQ     = 3'd3,
		WR_WAIT    = 3'd4,
		INTERLEAVE = 3'd5  // FEED gap left for other masters
	} state_t;

	state_t                    state;
	state_t                    state_n;
	logic                      request_n;
	logic                      retire_n;
	dma_cmd_pkg::tag_t         retire_tag_n;
	dma_bus_pkg::bus_req_t     bus_req_n;

	// Working copy of the command, addresses and count advance in place
	dma_cmd_pkg::dma_command_t cmd;
	dma_cmd_pkg::dma_command_t cmd_n;
	dma_bus_pkg::word_t        data;  // Word to write next
	dma_bus_pkg::word_t        data_n;

	assign o_q_read = (state == IDLE) && !i_q_empty;
	assign o_busy   = (state != IDLE) || o_retire;

	always_comb begin
		state_n      = state;
		request_n    = o_bus_request;
		retire_n     = 1'b0;
		retire_tag_n = o_retire_tag;
		bus_req_n    = o_bus_req;
		cmd_n        = cmd;
		data_n       = data;

		unique case (state)
			IDLE: begin
				if (!i_q_empty) begin
					cmd_n = i_q_command;
					// First access is issued straight from the latch
					case (i_q_command.dt)
						dma_cmd_pkg::WRITE: begin
							data_n    = i_q_command.value_or_from;
							request_n = 1'b1;
							bus_req_n = '{rw: 1'b1, address: i_q_command.to,
								wdata: i_q_command.value_or_from};
							state_n   = WR_WAIT;
						end
						dma_cmd_pkg::COPY, dma_cmd_pkg::FEED: begin
							request_n = 1'b1;
							bus_req_n = '{rw: 1'b0, address: i_q_command.value_or_from,
								wdata: '0};
							state_n   = RD_WAIT;
						end
						default: begin
							retire_n     = 1'b1;  // NONE
							retire_tag_n = i_q_command.tag;
						end
					endcase
				end
			end

			RD_REQ: begin
				request_n = 1'b1;
				bus_req_n = '{rw: 1'b0, address: cmd.value_or_from, wdata: '0};
				state_n   = RD_WAIT;
			end

			RD_WAIT: begin
				if (i_bus_ready) begin
					request_n           = 1'b0;
					data_n              = i_bus_rdata;
					cmd_n.value_or_from = cmd.value_or_from + dma_bus_pkg::ADDR_STEP;
					state_n             = WR_REQ;
				end
			end

			WR_REQ: begin
				request_n = 1'b1;
				bus_req_n = '{rw: 1'b1, address: cmd.to, wdata: data};
				state_n   = WR_WAIT;
			end

			WR_WAIT: begin
				if (i_bus_ready) begin
					request_n = 1'b0;
					if (cmd.count == '0) begin
						retire_n     = 1'b1;
						retire_tag_n = cmd.tag;
						state_n      = IDLE;
					end else begin
						cmd_n.count = cmd.count - 1'b1;
						if (cmd.dt != dma_cmd_pkg::FEED)
							cmd_n.to = cmd.to + dma_bus_pkg::ADDR_STEP;  // FEED target is fixed
						case (cmd.dt)
							dma_cmd_pkg::WRITE: state_n = WR_REQ;
							dma_cmd_pkg::COPY:  state_n = RD_REQ;
							default:            state_n = INTERLEAVE;
						endcase
					end
				end
			end

			INTERLEAVE: state_n = RD_REQ;

			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= IDLE;
			o_bus_request <= 1'b0;
			o_retire      <= 1'b0;
		end else begin
			state         <= state_n;
			o_bus_request <= request_n;
			o_retire      <= retire_n;
		end
	end

	always_ff @(posedge i_clock) begin
		cmd          <= cmd_n;
		data         <= data_n;
		o_bus_req    <= bus_req_n;
		o_retire_tag <= retire_tag_n;
	end

endmodule

/* logic/dma_top.sv */
// Command-queued DMA controller top, register front end into queue into engine
`timescale 1ns/1ps

module dma_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                    i_clock,
	input  logic                    i_rst_n,

	// CPU register window
	input  logic                    i_request,
	input  logic                    i_rw,
	input  dma_cmd_pkg::reg_index_t i_address,
	input  dma_bus_pkg::word_t      i_wdata,
	output dma_bus_pkg::word_t      o_rdata,
	output logic                    o_ready,

	// System bus master
	output logic                    o_bus_request,
	output dma_bus_pkg::bus_req_t   o_bus_req,
	input  logic                    i_bus_ready,
	input  dma_bus_pkg::word_t      i_bus_rdata
);
	logic                      q_write;
	logic                      q_read;
	logic                      q_full;
	logic                      q_empty;
	dma_cmd_pkg::dma_command_t q_wcommand;
	dma_cmd_pkg::dma_command_t q_rcommand;
	logic                      engine_busy;
	logic                      retire;
	dma_cmd_pkg::tag_t         retire_tag;

	dma_regs u_regs (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_rdata       (o_rdata),
		.o_ready       (o_ready),
		.o_q_write     (q_write),
		.o_q_command   (q_wcommand),
		.i_q_full      (q_full),
		.i_q_empty     (q_empty),
		.i_engine_busy (engine_busy),
		.i_retire      (retire),
		.i_retire_tag  (retire_tag)
	);

	dma_cmd_fifo #(
		.DEPTH (QUEUE_DEPTH)
	) u_queue (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_write (q_write),
		.i_wdata (q_wcommand),
		.i_read  (q_read),
		.o_rdata (q_rcommand),
		.o_empty (q_empty),
		.o_full  (q_full)
	);

	dma_engine u_engine (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_q_empty     (q_empty),
		.i_q_command   (q_rcommand),
		.o_q_read      (q_read),
		.o_busy        (engine_busy),
		.o_retire      (retire),
		.o_retire_tag  (retire_tag),
		.o_bus_request (o_bus_request),
		.o_bus_req     (o_bus_req),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

endmodule

/* testbench/tb_bus_memory.sv */
// Word memory model on the system bus with random wait states and a FEED write log
`timescale 1ns/1ps

module tb_bus_memory #(
	parameter int                 WORDS     = 256,
	parameter dma_bus_pkg::addr_t FEED_ADDR = 32'h0000_03fc,
	parameter logic [31:0]        SEED      = 32'he3754849
) (
	input  logic                  i_clock,
	input  logic                  i_rst_n,
	input  logic                  i_request,
	input  dma_bus_pkg::bus_req_t i_req,
	output logic                  o_ready,
	output dma_bus_pkg::word_t    o_rdata
);
	dma_bus_pkg::word_t mem [WORDS];
	dma_bus_pkg::word_t feed_log [$];  // Every word written to FEED_ADDR, in order

	logic [31:0] lcg_state;
	logic        active;     // Access accepted, counting wait states
	logic [1:0]  wait_left;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Start pattern built from the full word index
	function automatic dma_bus_pkg::word_t fill_word(input int index);
		return (dma_bus_pkg::word_t'(index) << 16) ^ dma_bus_pkg::word_t'(index) ^ 32'hc35a_0000;
	endfunction

	function automatic int word_index(input dma_bus_pkg::addr_t address);
		return int'(address[31:2]) % WORDS;
	endfunction

	// Responses change on the falling edge, away from the DUT sampling edge
	always @(negedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready   <= 1'b0;
			o_rdata   <= '0;
			active    <= 1'b0;
			wait_left <= '0;
			lcg_state <= SEED;
			for (int i = 0; i < WORDS; i++)
				mem[i] <= fill_word(i);
		end else if (o_ready) begin
			o_ready <= 1'b0;  // Ready lasts one cycle
		end else if (i_request && !active) begin
			lcg_state <= lcg_next(lcg_state);
			wait_left <= lcg_state[17:16];  // 0 to 3 wait states
			active    <= 1'b1;
		end else if (active) begin
			if (wait_left == 2'd0) begin
				active  <= 1'b0;
				o_ready <= 1'b1;
				if (i_req.rw) begin
					mem[word_index(i_req.address)] <= i_req.wdata;
					if (i_req.address == FEED_ADDR)
						feed_log.push_back(i_req.wdata);
				end else begin
					o_rdata <= mem[word_index(i_req.address)];
				end
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

/* testbench/tb_dma.sv */
// DMA controller testbench that programs commands over the CPU window and checks the bus
`timescale 1ns/1ps

module tb_dma;
	localparam int                 MEM_WORDS  = 256;
	localparam int                 WAIT_LIMIT = 4000;
	localparam dma_bus_pkg::addr_t FEED_ADDR  = 32'h0000_03fc;

	logic                    clock;
	logic                    rst_n;
	logic                    cpu_request;
	logic                    cpu_rw;
	dma_cmd_pkg::reg_index_t cpu_address;
	dma_bus_pkg::word_t      cpu_wdata;
	dma_bus_pkg::word_t      cpu_rdata;
	logic                    cpu_ready;
	logic                    bus_request;
	dma_bus_pkg::bus_req_t   bus_req;
	logic                    bus_ready;
	dma_bus_pkg::word_t      bus_rdata;
	logic                    feed_write_done;

	dma_bus_pkg::word_t exp_mem [MEM_WORDS];  // Expected memory image
	dma_bus_pkg::word_t fld_from;             // Shadow of the command fields
	dma_bus_pkg::addr_t fld_to;
	dma_bus_pkg::word_t fld_count;
	int                 checks = 0;
	int                 mismatches = 0;
	int                 protocol_errors = 0;
	int                 submitted = 0;
	int                 request_cycles = 0;
	logic               feed_running = 1'b0;

	dma_top #(.QUEUE_DEPTH(4)) DUT (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_request     (cpu_request),
		.i_rw          (cpu_rw),
		.i_address     (cpu_address),
		.i_wdata       (cpu_wdata),
		.o_rdata       (cpu_rdata),
		.o_ready       (cpu_ready),
		.o_bus_request (bus_request),
		.o_bus_req     (bus_req),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	tb_bus_memory #(.WORDS(MEM_WORDS), .FEED_ADDR(FEED_ADDR), .SEED(32'he3754849)) u_memory (
		.i_clock   (clock),
		.i_rst_n   (rst_n),
		.i_request (bus_request),
		.i_req     (bus_req),
		.o_ready   (bus_ready),
		.o_rdata   (bus_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock)
		if (bus_request)
			request_cycles <= request_cycles + 1;

	assign feed_write_done = bus_request && bus_ready && bus_req.rw;

	// Fields hold until ready
	assert property (@(posedge clock) disable iff (!rst_n)
		$past(bus_request && !bus_ready) |-> (bus_request && $stable(bus_req)))
	else begin
		protocol_errors++;
		$display("bus request dropped or changed before ready at %0t", $time);
	end

	// FEED leaves a spare bus cycle after each write
	assert property (@(posedge clock) disable iff (!rst_n)
		(feed_running && ($past(feed_write_done) || $past(feed_write_done, 2))) |-> !bus_request)
	else begin
		protocol_errors++;
		$display("bus request rose without the FEED idle cycle at %0t", $time);
	end

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s at %0t", what, $time);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic check_value(input string what, input dma_bus_pkg::word_t got,
		input dma_bus_pkg::word_t expected);
		checks++;
		assert (got === expected) else begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// One CPU access with the full request and ready handshake
	task automatic cpu_access(input logic rw, input dma_cmd_pkg::reg_index_t index,
		input dma_bus_pkg::word_t data, output dma_bus_pkg::word_t rdata);
		int cycles;
		cycles = 0;
		@(negedge clock);
		cpu_request = 1'b1;
		cpu_rw      = rw;
		cpu_address = index;
		cpu_wdata   = data;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_on_timeout("CPU ready");
		end while (!cpu_ready);
		rdata       = cpu_rdata;
		cpu_request = 1'b0;
		cycles      = 0;
		while (cpu_ready) begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_on_timeout("CPU ready to fall");
		end
	endtask

	task automatic cpu_write(input dma_cmd_pkg::reg_index_t index,
		input dma_bus_pkg::word_t data);
		dma_bus_pkg::word_t unused;
		cpu_access(1'b1, index, data, unused);
	endtask

	task automatic expect_reg(input dma_cmd_pkg::reg_index_t index,
		input dma_bus_pkg::word_t expected, input string what);
		dma_bus_pkg::word_t value;
		cpu_access(1'b0, index, '0, value);
		check_value(what, value, expected);
	endtask

	task automatic wait_idle();
		dma_bus_pkg::word_t status;
		int polls;
		polls = 0;
		cpu_access(1'b0, dma_cmd_pkg::REG_CONTROL, '0, status);
		while (status[0]) begin
			polls++;
			if (polls > WAIT_LIMIT)
				abort_on_timeout("engine idle");
			cpu_access(1'b0, dma_cmd_pkg::REG_CONTROL, '0, status);
		end
	endtask

	function automatic int word_index(input dma_bus_pkg::addr_t address);
		return int'(address[31:2]) % MEM_WORDS;
	endfunction

	// Expected effect of a command on memory
	task automatic model_command(input dma_cmd_pkg::dma_type_t dt);
		dma_bus_pkg::addr_t src;
		dma_bus_pkg::addr_t dst;
		src = fld_from;
		dst = fld_to;
		if (dt == dma_cmd_pkg::NONE)
			return;
		for (int n = 0; n <= int'(fld_count); n++) begin
			if (dt == dma_cmd_pkg::WRITE)
				exp_mem[word_index(dst)] = fld_from;
			else
				exp_mem[word_index(dst)] = exp_mem[word_index(src)];
			src = src + 32'd4;
			if (dt != dma_cmd_pkg::FEED)
				dst = dst + 32'd4;
		end
	endtask

	task automatic set_fields(input dma_bus_pkg::word_t from, input dma_bus_pkg::addr_t to,
		input dma_bus_pkg::word_t count);
		cpu_write(dma_cmd_pkg::REG_VALUE_FROM, from);
		cpu_write(dma_cmd_pkg::REG_TO, to);
		cpu_write(dma_cmd_pkg::REG_COUNT, count);
		fld_from  = from;
		fld_to    = to;
		fld_count = count;
	endtask

	task automatic enqueue(input dma_cmd_pkg::dma_type_t dt);
		cpu_write(dma_cmd_pkg::REG_CONTROL, dma_bus_pkg::word_t'(dt));
		submitted++;
		model_command(dt);
	endtask

	task automatic compare_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			check_value($sformatf("memory word %0d", i), u_memory.mem[i], exp_mem[i]);
	endtask

	initial begin
		dma_bus_pkg::word_t status;
		int cycles_before;
		cpu_request = 1'b0;
		cpu_rw      = 1'b0;
		cpu_address = '0;
		cpu_wdata   = '0;
		rst_n       = 1'b0;
		repeat (16) @(negedge clock);
		rst_n = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
			exp_mem[i] = u_memory.mem[i];  // Start image after the memory fill

		expect_reg(dma_cmd_pkg::REG_CONTROL, 32'd0, "status after reset");
		expect_reg(dma_cmd_pkg::REG_VALUE_FROM, 32'd0, "queued counter after reset");
		expect_reg(dma_cmd_pkg::REG_TO, 32'd0, "retired counter after reset");

		set_fields(32'hcafe_0001, 32'h0000_0100, 32'd3);
		enqueue(dma_cmd_pkg::WRITE);
		wait_idle();
		expect_reg(dma_cmd_pkg::REG_TO, 32'd1, "retired counter after WRITE");
		compare_memory();

		set_fields(32'h0000_0000, 32'h0000_0200, 32'd7);
		enqueue(dma_cmd_pkg::COPY);
		wait_idle();
		expect_reg(dma_cmd_pkg::REG_TO, 32'd2, "retired counter after COPY");
		compare_memory();

		feed_running = 1'b1;
		set_fields(32'h0000_0040, FEED_ADDR, 32'd4);
		enqueue(dma_cmd_pkg::FEED);
		wait_idle();
		feed_running = 1'b0;
		check_value("FEED log length", dma_bus_pkg::word_t'(u_memory.feed_log.size()), 32'd5);
		for (int n = 0; n < 5; n++)
			check_value($sformatf("FEED log entry %0d", n), u_memory.feed_log[n],
				exp_mem[16 + n]);
		compare_memory();

		// Long commands so the queue fills behind the first one
		set_fields(32'h0b0b_0b0b, 32'h0000_0280, 32'd31);
		repeat (5) enqueue(dma_cmd_pkg::WRITE);
		cpu_access(1'b0, dma_cmd_pkg::REG_CONTROL, '0, status);
		check_value("status with a full queue", status, 32'd3);
		// The queue is full here and this write waits for the engine to free an entry
		enqueue(dma_cmd_pkg::WRITE);
		expect_reg(dma_cmd_pkg::REG_TO, dma_bus_pkg::word_t'(submitted - 5),
			"retired counter once the stalled enqueue completes");
		wait_idle();
		expect_reg(dma_cmd_pkg::REG_VALUE_FROM, dma_bus_pkg::word_t'(submitted), "queued counter");
		expect_reg(dma_cmd_pkg::REG_TO, dma_bus_pkg::word_t'(submitted), "retired counter");
		compare_memory();

		cycles_before = request_cycles;
		enqueue(dma_cmd_pkg::NONE);
		wait_idle();
		expect_reg(dma_cmd_pkg::REG_TO, dma_bus_pkg::word_t'(submitted),
			"retired counter after NONE");
		check_value("bus request cycles during NONE", dma_bus_pkg::word_t'(request_cycles),
			dma_bus_pkg::word_t'(cycles_before));

		$display("checks %0d, mismatches %0d, protocol errors %0d",
			checks, mismatches, protocol_errors);
		if (mismatches == 0 && protocol_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
logic/dma_bus_pkg.sv
logic/dma_cmd_pkg.sv
logic/dma_cmd_fifo.sv
logic/dma_regs.sv
logic/dma_engine.sv
logic/dma_top.sv
testbench/tb_bus_memory.sv
testbench/tb_dma.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator; the log decides pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dma -f verilog.f \
	--Mdir obj_dir -o sim_dma > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_dma > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
